//--- src/uart_pkg.sv
// ----------------------------------------
// UART register map and frame constants
// registers are 32-bit words at index*4
// frames are 8N1, 8E1 or 8O1 only
// ----------------------------------------
package uart_pkg;

    localparam int UART_DATA_WIDTH    = 8;
    localparam int UART_DIVIDER_WIDTH = 16;
    localparam int UART_MIN_DIVIDER   = 4;
    localparam int UART_REG_NUM       = 6;

    localparam int UART_CONTROL_REG_POS     = 0;
    localparam int UART_STATUS_REG_POS      = 1;
    localparam int UART_CLK_DIVIDER_REG_POS = 2;
    localparam int UART_TX_DATA_REG_POS     = 3;
    localparam int UART_RX_DATA_REG_POS     = 4;
    localparam int UART_PARAM_REG_POS       = 5;

    typedef struct packed {
        logic parity_odd;
        logic parity_even;  // wins over parity_odd
        logic tx_reset;
        logic rx_reset;
    } uart_control_t;

    typedef struct packed {
        logic parity_err;   // flag of the RX head word
        logic tx_fifo_full;
        logic rx_fifo_full;
        logic tx_fifo_empty;
        logic rx_fifo_empty;
    } uart_status_t;

    typedef struct packed {
        logic                       parity_err;
        logic [UART_DATA_WIDTH-1:0] data;
    } uart_rx_word_t;

    typedef struct packed {
        logic [7:0]  reg_num;
        logic [15:0] fifo_depth;
        logic [7:0]  data_width;
    } uart_param_t;

    // first field is the highest index
    typedef struct packed {
        logic [31:0] param;
        logic [31:0] rx_data;
        logic [31:0] tx_data;
        logic [31:0] clk_divider;
        logic [31:0] status;
        logic [31:0] control;
    } uart_regs_t;

    localparam uart_regs_t UART_REG_INIT = '{
        clk_divider: 32'd16,
        default:     '0
    };

endpackage

//--- src/axil_pkg.sv
// ----------------------------------------
// reduced AXI-lite channels
// address and data share one write channel
// no strobes, no prot, no bursts
// ----------------------------------------
package axil_pkg;

    localparam int AXIL_ADDR_WIDTH = 8;
    localparam int AXIL_DATA_WIDTH = 32;

    localparam logic [1:0] AXIL_RESP_OKAY   = 2'd0;
    localparam logic [1:0] AXIL_RESP_SLVERR = 2'd2;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic [AXIL_DATA_WIDTH-1:0] data;
        logic                       valid;
        logic                       bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       ready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [AXIL_ADDR_WIDTH-1:0] addr;
        logic                       arvalid;
        logic                       rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic                       arready;
        logic                       rvalid;
        logic [AXIL_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 rresp;
    } axil_rd_rsp_t;

endpackage

//--- src/stream_fifo.sv
// ----------------------------------------
// first-word-fall-through stream FIFO
// DEPTH must be a power of two
// ----------------------------------------
`timescale 1ns/10ps

module stream_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  payload_t s_data_i,
    input  logic     s_valid_i,
    output logic     s_ready_o,
    output payload_t m_data_o,
    output logic     m_valid_o,
    input  logic     m_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign s_ready_o = count_q != CNT_W'(DEPTH);
    assign m_valid_o = count_q != '0;
    assign push      = s_valid_i && s_ready_o;
    assign pop       = m_ready_i && m_valid_o;
    assign m_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push)
            mem[wr_ptr_q] <= s_data_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push)
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // count never passes DEPTH and agrees with the pointers
    a_count_range : assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= CNT_W'(DEPTH));
    a_count_ptrs : assert property (@(posedge clk_i) disable iff (rst_i)
        PTR_W'(wr_ptr_q - rd_ptr_q) == count_q[PTR_W-1:0]);

endmodule

//--- src/uart_tx.sv
// ----------------------------------------
// UART serializer, one stop bit
// divider is read live, keep it >= 4
// ----------------------------------------
`timescale 1ns/10ps

module uart_tx
    import uart_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [UART_DIVIDER_WIDTH-1:0] clk_divider_i,
    input  uart_control_t                 control_i,
    input  logic [UART_DATA_WIDTH-1:0]    s_data_i,
    input  logic                          s_valid_i,
    output logic                          s_ready_o,
    output logic                          uart_tx_o
);

    localparam int FRAME_W = UART_DATA_WIDTH + 3;  // start, data, parity, stop
    localparam int BIT_W   = $clog2(FRAME_W);

    logic [FRAME_W-1:0]            shift_q;
    logic [UART_DIVIDER_WIDTH-1:0] cnt_q;
    logic [BIT_W-1:0]              bits_left_q;
    logic                          busy_q;
    logic                          par_en;
    logic                          par_bit;
    logic                          load;

    assign par_en    = control_i.parity_even | control_i.parity_odd;
    assign par_bit   = control_i.parity_even ? ^s_data_i : ~^s_data_i;
    assign s_ready_o = !busy_q;
    assign load      = s_valid_i && !busy_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            shift_q <= '1;                 // line idles high
        end else if (load) begin
            busy_q      <= 1'b1;
            shift_q     <= {1'b1, par_en ? par_bit : 1'b1, s_data_i, 1'b0};
            cnt_q       <= clk_divider_i - 1'b1;
            bits_left_q <= par_en ? BIT_W'(FRAME_W - 1) : BIT_W'(FRAME_W - 2);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                shift_q     <= {1'b1, shift_q[FRAME_W-1:1]};
                cnt_q       <= clk_divider_i - 1'b1;
                bits_left_q <= bits_left_q - 1'b1;
                busy_q      <= bits_left_q != '0;  // stop bit done
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign uart_tx_o = shift_q[0];

    a_tx_min_div : assert property (@(posedge clk_i) disable iff (rst_i)
        busy_q |-> clk_divider_i >= UART_DIVIDER_WIDTH'(UART_MIN_DIVIDER));

endmodule

//--- src/uart_rx.sv
// ----------------------------------------
// UART deserializer with mid-bit sampling
// no back-pressure, one word per frame
// a low stop bit drops the frame
// ----------------------------------------
`timescale 1ns/10ps

module uart_rx
    import uart_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [UART_DIVIDER_WIDTH-1:0] clk_divider_i,
    input  uart_control_t                 control_i,
    input  logic                          uart_rx_i,
    output uart_rx_word_t                 m_word_o,
    output logic                          m_valid_o
);

    localparam int FRAME_W = UART_DATA_WIDTH + 3;
    localparam int BIT_W   = $clog2(FRAME_W);

    logic                          rx_meta_q;
    logic                          rx_q;
    logic                          busy_q;
    logic [UART_DIVIDER_WIDTH-1:0] cnt_q;
    logic [BIT_W-1:0]              bit_idx_q;
    logic [BIT_W-1:0]              last_idx_q;
    logic                          par_en_q;
    logic                          par_even_q;
    logic [UART_DATA_WIDTH-1:0]    data_q;
    logic                          par_q;
    logic                          m_valid_q;
    uart_rx_word_t                 word_q;
    logic                          sample;
    logic                          exp_par;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_q      <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_q      <= rx_meta_q;
        end
    end

    assign sample  = busy_q && cnt_q == '0;
    assign exp_par = par_even_q ? ^data_q : ~^data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            m_valid_q <= 1'b0;
        end else begin
            m_valid_q <= 1'b0;
            if (!busy_q) begin
                if (!rx_q) begin           // start edge
                    busy_q     <= 1'b1;
                    cnt_q      <= (clk_divider_i >> 1) - 1'b1;
                    bit_idx_q  <= '0;
                    par_en_q   <= control_i.parity_even | control_i.parity_odd;
                    par_even_q <= control_i.parity_even;
                    last_idx_q <= (control_i.parity_even | control_i.parity_odd) ?
                                  BIT_W'(FRAME_W - 1) : BIT_W'(FRAME_W - 2);
                end
            end else if (!sample) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q     <= clk_divider_i - 1'b1;
                bit_idx_q <= bit_idx_q + 1'b1;
                if (bit_idx_q == '0) begin
                    busy_q <= !rx_q;       // glitch, not a start bit
                end else if (bit_idx_q == last_idx_q) begin
                    busy_q    <= 1'b0;
                    m_valid_q <= rx_q;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample && bit_idx_q != '0) begin
            if (bit_idx_q == last_idx_q) begin
                word_q.data       <= data_q;
                word_q.parity_err <= par_en_q && (par_q != exp_par);
            end else if (int'(bit_idx_q) <= UART_DATA_WIDTH) begin
                data_q <= {rx_q, data_q[UART_DATA_WIDTH-1:1]};  // lsb first
            end else begin
                par_q <= rx_q;
            end
        end
    end

    assign m_word_o  = word_q;
    assign m_valid_o = m_valid_q;

    a_rx_min_div : assert property (@(posedge clk_i) disable iff (rst_i)
        busy_q |-> clk_divider_i >= UART_DIVIDER_WIDTH'(UART_MIN_DIVIDER));

endmodule

//--- src/uart_axil_regs.sv
// ----------------------------------------
// AXI-lite register slave for the UART
// one outstanding write and one read
// low address bits are ignored
// ----------------------------------------
`timescale 1ns/10ps

module uart_axil_regs
    import uart_pkg::*;
    import axil_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  axil_wr_req_t                  wr_req_i,
    output axil_wr_rsp_t                  wr_rsp_o,
    input  axil_rd_req_t                  rd_req_i,
    output axil_rd_rsp_t                  rd_rsp_o,
    input  uart_status_t                  status_i,
    input  uart_rx_word_t                 rx_word_i,
    output uart_control_t                 control_o,
    output logic [UART_DIVIDER_WIDTH-1:0] clk_divider_o,
    output logic [UART_DATA_WIDTH-1:0]    tx_data_o,
    output logic                          tx_valid_o,
    output logic                          rx_pop_o
);

    localparam int IDX_W = AXIL_ADDR_WIDTH - 2;

    uart_regs_t                                   regs_q;
    uart_regs_t                                   rd_regs;
    uart_param_t                                  param;
    logic [UART_REG_NUM-1:0][AXIL_DATA_WIDTH-1:0] rd_words;
    logic [IDX_W-1:0]                             wr_idx;
    logic [IDX_W-1:0]                             rd_idx;
    logic                                         wr_fire;
    logic                                         wr_ok;
    logic                                         rd_fire;
    logic                                         rd_err;
    logic                                         bvalid_q;
    logic [1:0]                                   bresp_q;
    logic                                         rvalid_q;
    logic [AXIL_DATA_WIDTH-1:0]                   rdata_q;
    logic [1:0]                                   rresp_q;

    assign wr_idx  = wr_req_i.addr[AXIL_ADDR_WIDTH-1:2];
    assign wr_fire = wr_req_i.valid && !bvalid_q;
    assign wr_ok   = int'(wr_idx) == UART_CONTROL_REG_POS ||
                     int'(wr_idx) == UART_CLK_DIVIDER_REG_POS ||
                     int'(wr_idx) == UART_TX_DATA_REG_POS;

    assign rd_idx  = rd_req_i.addr[AXIL_ADDR_WIDTH-1:2];
    assign rd_fire = rd_req_i.arvalid && !rvalid_q;
    assign rd_err  = int'(rd_idx) >= UART_REG_NUM || int'(rd_idx) == UART_TX_DATA_REG_POS;

    assign param = '{reg_num:    8'(UART_REG_NUM),
                     fifo_depth: 16'(FIFO_DEPTH),
                     data_width: 8'(UART_DATA_WIDTH)};

    always_comb begin
        rd_regs         = regs_q;
        rd_regs.status  = 32'(status_i);
        rd_regs.tx_data = '0;           // write-only
        rd_regs.rx_data = status_i.rx_fifo_empty ? '0 : 32'(rx_word_i);
        rd_regs.param   = 32'(param);
    end

    assign rd_words = rd_regs;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs_q   <= UART_REG_INIT;
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            if (int'(wr_idx) == UART_CONTROL_REG_POS)
                regs_q.control <= 32'(wr_req_i.data[$bits(uart_control_t)-1:0]);
            if (int'(wr_idx) == UART_CLK_DIVIDER_REG_POS)
                regs_q.clk_divider <= 32'(wr_req_i.data[UART_DIVIDER_WIDTH-1:0]);
        end else if (wr_req_i.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            rvalid_q <= 1'b0;
        else if (rd_fire)
            rvalid_q <= 1'b1;
        else if (rd_req_i.rready)
            rvalid_q <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire)
            bresp_q <= wr_ok ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
        if (rd_fire) begin
            rdata_q <= (int'(rd_idx) < UART_REG_NUM) ? rd_words[rd_idx] : '0;
            rresp_q <= rd_err ? AXIL_RESP_SLVERR : AXIL_RESP_OKAY;
        end
    end

    assign wr_rsp_o = '{ready: !bvalid_q, bvalid: bvalid_q, bresp: bresp_q};
    assign rd_rsp_o = '{arready: !rvalid_q, rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

    assign control_o     = uart_control_t'(regs_q.control[$bits(uart_control_t)-1:0]);
    assign clk_divider_o = regs_q.clk_divider[UART_DIVIDER_WIDTH-1:0];
    assign tx_data_o     = wr_req_i.data[UART_DATA_WIDTH-1:0];
    assign tx_valid_o    = wr_fire && int'(wr_idx) == UART_TX_DATA_REG_POS;
    assign rx_pop_o      = rd_fire && int'(rd_idx) == UART_RX_DATA_REG_POS &&
                           !status_i.rx_fifo_empty;

    // a pending response holds still until the master takes it
    a_b_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_q && !wr_req_i.bready |=> bvalid_q && $stable(bresp_q));
    a_r_hold : assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_q && !rd_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule

//--- src/axil_uart.sv
// ----------------------------------------
// AXI-lite UART, single clock domain
// soft resets hold a path while set
// ----------------------------------------
`timescale 1ns/10ps

module axil_uart
    import uart_pkg::*;
    import axil_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  axil_wr_req_t wr_req_i,
    output axil_wr_rsp_t wr_rsp_o,
    input  axil_rd_req_t rd_req_i,
    output axil_rd_rsp_t rd_rsp_o,
    input  logic         uart_rx_i,
    output logic         uart_tx_o
);

    uart_control_t                 control;
    uart_status_t                  status;
    logic [UART_DIVIDER_WIDTH-1:0] clk_divider;
    logic                          tx_rst;
    logic                          rx_rst;

    logic [UART_DATA_WIDTH-1:0]    tx_push_data;
    logic                          tx_push_valid;
    logic                          tx_push_ready;
    logic [UART_DATA_WIDTH-1:0]    tx_head;
    logic                          tx_head_valid;
    logic                          tx_head_ready;

    uart_rx_word_t                 rx_word;
    logic                          rx_word_valid;
    logic                          rx_push_ready;
    uart_rx_word_t                 rx_head;
    logic                          rx_head_valid;
    logic                          rx_pop;

    assign tx_rst = rst_i | control.tx_reset;
    assign rx_rst = rst_i | control.rx_reset;

    assign status = '{parity_err:    rx_head_valid & rx_head.parity_err,
                      tx_fifo_full:  !tx_push_ready,
                      rx_fifo_full:  !rx_push_ready,
                      tx_fifo_empty: !tx_head_valid,
                      rx_fifo_empty: !rx_head_valid};

    uart_axil_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_uart_axil_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_req_i     (wr_req_i),
        .wr_rsp_o     (wr_rsp_o),
        .rd_req_i     (rd_req_i),
        .rd_rsp_o     (rd_rsp_o),
        .status_i     (status),
        .rx_word_i    (rx_head),
        .control_o    (control),
        .clk_divider_o(clk_divider),
        .tx_data_o    (tx_push_data),
        .tx_valid_o   (tx_push_valid),
        .rx_pop_o     (rx_pop)
    );

    stream_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(logic [UART_DATA_WIDTH-1:0])
    ) i_fifo_tx (
        .clk_i    (clk_i),
        .rst_i    (tx_rst),
        .s_data_i (tx_push_data),
        .s_valid_i(tx_push_valid),     // dropped when full
        .s_ready_o(tx_push_ready),
        .m_data_o (tx_head),
        .m_valid_o(tx_head_valid),
        .m_ready_i(tx_head_ready)
    );

    uart_tx i_uart_tx (
        .clk_i        (clk_i),
        .rst_i        (tx_rst),
        .clk_divider_i(clk_divider),
        .control_i    (control),
        .s_data_i     (tx_head),
        .s_valid_i    (tx_head_valid),
        .s_ready_o    (tx_head_ready),
        .uart_tx_o    (uart_tx_o)
    );

    uart_rx i_uart_rx (
        .clk_i        (clk_i),
        .rst_i        (rx_rst),
        .clk_divider_i(clk_divider),
        .control_i    (control),
        .uart_rx_i    (uart_rx_i),
        .m_word_o     (rx_word),
        .m_valid_o    (rx_word_valid)
    );

    stream_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(uart_rx_word_t)
    ) i_fifo_rx (
        .clk_i    (clk_i),
        .rst_i    (rx_rst),
        .s_data_i (rx_word),
        .s_valid_i(rx_word_valid),     // lost when full
        .s_ready_o(rx_push_ready),
        .m_data_o (rx_head),
        .m_valid_o(rx_head_valid),
        .m_ready_i(rx_pop)
    );

endmodule

//--- dv/axil_uart_tb.sv
// ----------------------------------------
// testbench for axil_uart with FIFO_DEPTH 4
// loopback by default, tb serial driver for
// bad parity frames; watchdog ends the run
// ----------------------------------------
`timescale 1ns/10ps

module axil_uart_tb
    import uart_pkg::*;
    import axil_pkg::*;
();

    localparam int DEPTH = 4;

    typedef enum {MODE_LOOP, MODE_DRIVE, MODE_FILL} mode_t;

    typedef struct {
        string       name;
        mode_t       mode;
        logic [3:0]  control;
        int          divider;
        int          n_bytes;
        logic [5:0]  bad_par;
        logic [7:0]  bytes [6];
        int          n_exp;
        logic [31:0] exp_words [6];
    } test_entry_t;

    logic         clk_i;
    logic         rst_i;
    axil_wr_req_t wr_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_req_t rd_req;
    axil_rd_rsp_t rd_rsp;
    logic         uart_rx_i;
    logic         uart_tx_o;
    logic         loop_sel;
    logic         drv_line;

    test_entry_t  tests [10];
    int           n_tests;
    logic [1:0]   wr_resp;
    logic [1:0]   rd_resp;
    logic [31:0]  rd_data;
    string        test_name;
    int           test_errors;
    int           tests_run;
    int           tests_failed;
    int           cycle_count;
    int           cycle_limit;
    int           cur_div;
    int           cur_frame_bits;
    int           frames_seen;
    int           mon_skip;
    int           seed_ret;

    axil_uart #(
        .FIFO_DEPTH(DEPTH)
    ) i_axil_uart (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_req_i (wr_req),
        .wr_rsp_o (wr_rsp),
        .rd_req_i (rd_req),
        .rd_rsp_o (rd_rsp),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o)
    );

    assign uart_rx_i = loop_sel ? uart_tx_o : drv_line;

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no progress after %0d cycles, run stopped", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    // counts frames leaving the transmitter, skips to the middle of each stop bit
    always @(negedge clk_i) begin
        if (mon_skip > 0) begin
            mon_skip--;
        end else if (uart_tx_o === 1'b0) begin
            frames_seen++;
            mon_skip = (cur_frame_bits - 1) * cur_div + cur_div / 2 - 1;
        end
    end

    function automatic logic [7:0] reg_addr(input int idx);
        return 8'(idx * 4);
    endfunction

    function automatic logic [31:0] expected_word(input logic [7:0] data, input logic bad);
        return {23'd0, bad, data};
    endfunction

    task automatic add_test(input string name, input mode_t mode, input logic [3:0] control,
                            input int divider, input int n_bytes, input logic [5:0] bad_par,
                            input bit use_fixed, input logic [47:0] fixed);
        int k;
        tests[n_tests].name    = name;
        tests[n_tests].mode    = mode;
        tests[n_tests].control = control;
        tests[n_tests].divider = divider;
        tests[n_tests].n_bytes = n_bytes;
        tests[n_tests].bad_par = bad_par;
        for (k = 0; k < 6; k++) begin
            tests[n_tests].bytes[k]     = use_fixed ? fixed[8*k +: 8] : 8'($urandom);
            tests[n_tests].exp_words[k] = expected_word(tests[n_tests].bytes[k], bad_par[k]);
        end
        // only the oldest DEPTH bytes survive a full RX FIFO
        tests[n_tests].n_exp = (mode == MODE_FILL) ? DEPTH : n_bytes;
        n_tests++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", test_name, test_errors);
        end else begin
            $display("PASS %s", test_name);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, got);
            test_errors++;
        end
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        wr_req.addr   = addr;
        wr_req.data   = data;
        wr_req.valid  = 1'b1;
        wr_req.bready = 1'b1;
        while (!wr_rsp.ready)
            @(negedge clk_i);
        @(negedge clk_i);               // taken on the edge before
        wr_req.valid = 1'b0;
        while (!wr_rsp.bvalid)
            @(negedge clk_i);
        wr_resp = wr_rsp.bresp;
    endtask

    task automatic bus_read(input logic [7:0] addr);
        @(negedge clk_i);
        rd_req.addr    = addr;
        rd_req.arvalid = 1'b1;
        rd_req.rready  = 1'b1;
        while (!rd_rsp.arready)
            @(negedge clk_i);
        @(negedge clk_i);
        rd_req.arvalid = 1'b0;
        while (!rd_rsp.rvalid)
            @(negedge clk_i);
        rd_data = rd_rsp.rdata;
        rd_resp = rd_rsp.rresp;
    endtask

    task automatic configure(input logic [3:0] control, input int divider);
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'(control));
        check_value("control bresp", AXIL_RESP_OKAY, wr_resp);
        bus_write(reg_addr(UART_CLK_DIVIDER_REG_POS), divider);
        check_value("divider bresp", AXIL_RESP_OKAY, wr_resp);
        cur_div        = divider;
        cur_frame_bits = (control[2] | control[3]) ? 11 : 10;
    endtask

    task automatic wait_rx_nonempty();
        bus_read(reg_addr(UART_STATUS_REG_POS));
        while (rd_data[0])
            bus_read(reg_addr(UART_STATUS_REG_POS));
    endtask

    // start, data lsb first, parity when enabled, stop
    task automatic send_frame(input logic [7:0] data, input logic [3:0] control, input logic bad);
        logic [10:0] bits;
        logic        par;
        int          n;
        int          i;
        par = (control[2] ? ^data : ~^data) ^ bad;
        if (control[2] | control[3]) begin
            bits = {1'b1, par, data, 1'b0};
            n    = 11;
        end else begin
            bits = {2'b11, data, 1'b0};
            n    = 10;
        end
        @(negedge clk_i);
        for (i = 0; i < n; i++) begin
            drv_line = bits[i];
            repeat (cur_div) @(negedge clk_i);
        end
        drv_line = 1'b1;
    endtask

    task automatic run_entry(input int t);
        int k;
        int frames_before;
        begin_test(tests[t].name);
        loop_sel = tests[t].mode != MODE_DRIVE;
        configure(tests[t].control, tests[t].divider);
        case (tests[t].mode)
            MODE_LOOP: begin
                for (k = 0; k < tests[t].n_bytes; k++) begin
                    bus_write(reg_addr(UART_TX_DATA_REG_POS), 32'(tests[t].bytes[k]));
                    check_value("tx_data bresp", AXIL_RESP_OKAY, wr_resp);
                    wait_rx_nonempty();
                    bus_read(reg_addr(UART_RX_DATA_REG_POS));
                    check_value("rx word", tests[t].exp_words[k], rd_data);
                end
            end
            MODE_DRIVE: begin
                for (k = 0; k < tests[t].n_bytes; k++) begin
                    send_frame(tests[t].bytes[k], tests[t].control, tests[t].bad_par[k]);
                    wait_rx_nonempty();
                    check_value("status parity_err", 32'(tests[t].bad_par[k]), 32'(rd_data[4]));
                    bus_read(reg_addr(UART_RX_DATA_REG_POS));
                    check_value("rx word", tests[t].exp_words[k], rd_data);
                end
            end
            default: begin
                frames_before = frames_seen;
                for (k = 0; k < tests[t].n_bytes; k++)
                    bus_write(reg_addr(UART_TX_DATA_REG_POS), 32'(tests[t].bytes[k]));
                check_value("bresp of dropped byte", AXIL_RESP_OKAY, wr_resp);
                bus_read(reg_addr(UART_STATUS_REG_POS));
                check_value("tx_fifo_full", 1, 32'(rd_data[3]));
                while (!rd_data[2])
                    bus_read(reg_addr(UART_STATUS_REG_POS));
                repeat (12 * tests[t].divider) @(negedge clk_i);  // one more frame time
                check_value("frames sent", DEPTH + 1, frames_seen - frames_before);
                bus_read(reg_addr(UART_STATUS_REG_POS));
                check_value("rx_fifo_full", 1, 32'(rd_data[2]));
                for (k = 0; k < tests[t].n_exp; k++) begin
                    bus_read(reg_addr(UART_RX_DATA_REG_POS));
                    check_value("rx word", tests[t].exp_words[k], rd_data);
                end
            end
        endcase
        bus_read(reg_addr(UART_RX_DATA_REG_POS));
        check_value("empty rx_data", 0, rd_data);
        check_value("empty rx_data rresp", AXIL_RESP_OKAY, rd_resp);
        end_test();
    endtask

    task automatic check_reset_values();
        begin_test("reset_values");
        bus_read(reg_addr(UART_CONTROL_REG_POS));
        check_value("control", 0, rd_data);
        check_value("control rresp", AXIL_RESP_OKAY, rd_resp);
        bus_read(reg_addr(UART_CLK_DIVIDER_REG_POS));
        check_value("clk_divider", 16, rd_data);
        bus_read(reg_addr(UART_STATUS_REG_POS));
        check_value("status", 32'h3, rd_data);  // both empty, neither full
        bus_read(reg_addr(UART_PARAM_REG_POS));
        check_value("param", {8'd6, 16'(DEPTH), 8'd8}, rd_data);
        check_value("idle tx line", 1, 32'(uart_tx_o));
        end_test();
    endtask

    task automatic check_register_access();
        begin_test("register_access");
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'hc);
        check_value("control bresp", AXIL_RESP_OKAY, wr_resp);
        bus_read(reg_addr(UART_CONTROL_REG_POS));
        check_value("control", 32'hc, rd_data);
        bus_write(reg_addr(UART_CLK_DIVIDER_REG_POS), 32'h1234);
        check_value("divider bresp", AXIL_RESP_OKAY, wr_resp);
        bus_read(reg_addr(UART_CLK_DIVIDER_REG_POS));
        check_value("clk_divider", 32'h1234, rd_data);
        configure(4'h0, 16);
        bus_write(reg_addr(UART_STATUS_REG_POS), 32'hff);
        check_value("status bresp", AXIL_RESP_SLVERR, wr_resp);
        bus_read(reg_addr(UART_STATUS_REG_POS));
        check_value("status", 32'h3, rd_data);
        bus_write(reg_addr(UART_PARAM_REG_POS), 32'h0);
        check_value("param bresp", AXIL_RESP_SLVERR, wr_resp);
        bus_read(reg_addr(UART_PARAM_REG_POS));
        check_value("param", {8'd6, 16'(DEPTH), 8'd8}, rd_data);
        bus_write(8'h20, 32'h1);
        check_value("unmapped bresp", AXIL_RESP_SLVERR, wr_resp);
        bus_read(8'h18);
        check_value("unmapped rresp", AXIL_RESP_SLVERR, rd_resp);
        bus_read(reg_addr(UART_TX_DATA_REG_POS));
        check_value("tx_data rresp", AXIL_RESP_SLVERR, rd_resp);
        check_value("tx_data read", 0, rd_data);
        end_test();
    endtask

    task automatic check_soft_resets();
        begin_test("soft_reset_rx");
        loop_sel = 1'b1;
        configure(4'h0, 4);
        bus_write(reg_addr(UART_TX_DATA_REG_POS), 32'h3c);
        wait_rx_nonempty();
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'h1);
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'h0);
        bus_read(reg_addr(UART_STATUS_REG_POS));
        check_value("rx_fifo_empty", 1, 32'(rd_data[0]));
        bus_read(reg_addr(UART_CLK_DIVIDER_REG_POS));
        check_value("clk_divider", 4, rd_data);
        end_test();

        begin_test("soft_reset_tx");
        loop_sel = 1'b0;                // keep the receiver quiet
        configure(4'h0, 200);
        repeat (3) bus_write(reg_addr(UART_TX_DATA_REG_POS), 32'ha5);
        bus_read(reg_addr(UART_STATUS_REG_POS));
        check_value("tx_fifo_empty before", 0, 32'(rd_data[1]));
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'h2);
        bus_write(reg_addr(UART_CONTROL_REG_POS), 32'h0);
        bus_read(reg_addr(UART_STATUS_REG_POS));
        check_value("tx_fifo_empty", 1, 32'(rd_data[1]));
        check_value("tx_fifo_full", 0, 32'(rd_data[3]));
        bus_read(reg_addr(UART_CLK_DIVIDER_REG_POS));
        check_value("clk_divider", 200, rd_data);
        check_value("idle tx line", 1, 32'(uart_tx_o));
        end_test();
    endtask

    initial begin
        int t;
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        wr_req         = '0;
        rd_req         = '0;
        loop_sel       = 1'b1;
        drv_line       = 1'b1;
        cur_div        = 16;
        cur_frame_bits = 10;
        cycle_count    = 0;
        seed_ret       = $urandom(77826);

        add_test("loop_8n1_div4", MODE_LOOP, 4'h0, 4, 4, 6'b0, 1'b1, 48'h0000_ff00_a355);
        add_test("loop_8e1_div4", MODE_LOOP, 4'h4, 4, 4, 6'b0, 1'b0, 48'h0);
        add_test("loop_8o1_div4", MODE_LOOP, 4'h8, 4, 4, 6'b0, 1'b0, 48'h0);
        add_test("loop_8n1_div10", MODE_LOOP, 4'h0, 10, 3, 6'b0, 1'b0, 48'h0);
        add_test("loop_8e1_div10", MODE_LOOP, 4'h4, 10, 3, 6'b0, 1'b0, 48'h0);
        add_test("loop_8o1_div10", MODE_LOOP, 4'h8, 10, 3, 6'b0, 1'b0, 48'h0);
        add_test("parity_err_even", MODE_DRIVE, 4'h4, 10, 2, 6'b000001, 1'b0, 48'h0);
        add_test("parity_err_odd", MODE_DRIVE, 4'h8, 10, 2, 6'b000001, 1'b0, 48'h0);
        add_test("fifo_limits", MODE_FILL, 4'h0, 200, 6, 6'b0, 1'b0, 48'h0);

        cycle_limit = 2000;
        for (t = 0; t < n_tests; t++)
            cycle_limit += tests[t].n_bytes * 12 * tests[t].divider;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        check_reset_values();
        check_register_access();
        for (t = 0; t < n_tests; t++)
            run_entry(t);
        check_soft_resets();

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- flist.f
src/uart_pkg.sv
src/axil_pkg.sv
src/stream_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_axil_regs.sv
src/axil_uart.sv
dv/axil_uart_tb.sv
